// ==== common/mgmt_pkg.sv ====
package mgmt_pkg;

	// PLL setup as programmed over housekeeping SPI
	typedef struct packed {
		logic        ena;
		logic        dco_ena;
		logic        bypass;
		logic [2:0]  sel;
		logic [2:0]  sel90;
		logic [4:0]  div;
		logic [25:0] trim;
	} pll_cfg_t;

	// SPI pins after synchronization
	// Edge strobes last one core cycle
	typedef struct packed {
		logic sck_rise;
		logic sck_fall;
		logic csb;
		logic sdi;
	} spi_ev_t;

	// Byte access from the SPI slave into the register file
	typedef struct packed {
		logic       wr;
		logic       rd;
		logic [7:0] addr;
		logic [7:0] wdata;
	} hk_bus_t;

	// Command byte values
	localparam logic [7:0] HK_CMD_WRITE = 8'h80;
	localparam logic [7:0] HK_CMD_READ  = 8'h40;

	// Register map
	localparam logic [7:0] REG_MASK_REV0  = 8'h01;
	localparam logic [7:0] REG_MASK_REV1  = 8'h02;
	localparam logic [7:0] REG_MASK_REV2  = 8'h03;
	localparam logic [7:0] REG_MASK_REV3  = 8'h04;
	localparam logic [7:0] REG_PLL_ENA    = 8'h08;
	localparam logic [7:0] REG_PLL_BYPASS = 8'h09;
	localparam logic [7:0] REG_IRQ        = 8'h0A;
	localparam logic [7:0] REG_EXT_RESET  = 8'h0B;
	localparam logic [7:0] REG_TRAP       = 8'h0C;
	localparam logic [7:0] REG_PLL_SEL    = 8'h0D;
	localparam logic [7:0] REG_PLL_DIV    = 8'h0E;
	// Trim is little-endian over four bytes
	localparam logic [7:0] REG_PLL_TRIM0  = 8'h10;
	localparam logic [7:0] REG_PLL_TRIM1  = 8'h11;
	localparam logic [7:0] REG_PLL_TRIM2  = 8'h12;
	localparam logic [7:0] REG_PLL_TRIM3  = 8'h13;

	// Boot with the PLL bypassed and a divide of four
	localparam pll_cfg_t PLL_CFG_RESET = '{
		ena:     1'b0,
		dco_ena: 1'b0,
		bypass:  1'b1,
		sel:     3'd0,
		sel90:   3'd0,
		div:     5'd4,
		trim:    26'd0
	};

endpackage

// ==== housekeeping/hk_pin_sync.sv ====
`timescale 1ns/1ps

module hk_pin_sync #(
	parameter int MPRJ_IO_PADS = 38
) (
	input  logic                    clock,
	input  logic                    rst_i,
	input  logic [MPRJ_IO_PADS-1:0] mgmt_in_data_i,
	input  logic [MPRJ_IO_PADS-1:0] mgmt_out_data_i,
	input  logic                    hk_connect_i,
	output mgmt_pkg::spi_ev_t       spi_ev_o
);
	// Bit positions inside the synchronizer vectors
	localparam int B_SCK = 2;
	localparam int B_CSB = 1;
	localparam int B_SDI = 0;

	// Idle pin state with CSB deasserted
	localparam logic [2:0] PIN_IDLE = 3'b010;

	logic [MPRJ_IO_PADS-1:0] pin_src;
	logic [2:0]              pin_raw;
	logic [2:0]              sync1_q;
	logic [2:0]              sync2_q;
	logic                    sck_last_q;

	// SoC drives the slave directly when hk_connect is set
	assign pin_src = hk_connect_i ? mgmt_out_data_i : mgmt_in_data_i;

	// SCK on bit 4, CSB on bit 3, SDI on bit 2
	assign pin_raw = {pin_src[4], pin_src[3], pin_src[2]};

	always_ff @(posedge clock) begin
		if (rst_i) begin
			sync1_q    <= PIN_IDLE;
			sync2_q    <= PIN_IDLE;
			sck_last_q <= 1'b0;
			spi_ev_o   <= '{sck_rise: 1'b0, sck_fall: 1'b0, csb: 1'b1, sdi: 1'b0};
		end else begin
			// Two stage synchronizer
			sync1_q    <= pin_raw;
			sync2_q    <= sync1_q;
			sck_last_q <= sync2_q[B_SCK];
			// Edge detect against the previous synchronized SCK
			spi_ev_o.sck_rise <= sync2_q[B_SCK] & ~sck_last_q;
			spi_ev_o.sck_fall <= ~sync2_q[B_SCK] & sck_last_q;
			// Levels delayed to stay aligned with the strobes
			spi_ev_o.csb      <= sync2_q[B_CSB];
			spi_ev_o.sdi      <= sync2_q[B_SDI];
		end
	end

endmodule

// ==== housekeeping/hk_spi_slave.sv ====
`timescale 1ns/1ps

module hk_spi_slave (
	input  logic              clock,
	input  logic              rst_i,
	input  mgmt_pkg::spi_ev_t spi_ev_i,
	output mgmt_pkg::hk_bus_t bus_o,
	input  logic [7:0]        rdata_i,
	output logic              sdo_o,
	output logic              sdo_enb_o
);
	import mgmt_pkg::*;

	typedef enum logic [1:0] {
		ST_CMD,
		ST_ADDR,
		ST_DATA,
		ST_IGNORE
	} state_t;

	state_t     state_q;
	logic [2:0] bit_cnt_q;
	logic [6:0] shift_in_q;
	logic [7:0] shift_out_q;
	logic [7:0] addr_q;
	logic [7:0] wdata_q;
	logic       rd_mode_q;
	logic       done_q;
	logic       load_q;
	logic [7:0] byte_in;
	logic       byte_end;
	logic       cmd_valid;

	// Byte as it stands with the bit arriving this cycle
	assign byte_in = {shift_in_q, spi_ev_i.sdi};

	// Eighth rising edge of the current byte
	assign byte_end = spi_ev_i.sck_rise && !spi_ev_i.csb && (bit_cnt_q == 3'd7);

	assign cmd_valid = (byte_in == HK_CMD_WRITE) || (byte_in == HK_CMD_READ);

	// Frame FSM
	// CSB high holds the slave idle and aborts a frame in flight
	always_ff @(posedge clock) begin
		if (rst_i || spi_ev_i.csb) begin
			state_q   <= ST_CMD;
			bit_cnt_q <= 3'd0;
		end else if (spi_ev_i.sck_rise) begin
			bit_cnt_q <= bit_cnt_q + 3'd1;
			if (bit_cnt_q == 3'd7) begin
				case (state_q)
					ST_CMD:  state_q <= cmd_valid ? ST_ADDR : ST_IGNORE;
					ST_ADDR: state_q <= ST_DATA;
					default: state_q <= state_q;
				endcase
			end
		end
	end

	// Command direction, address pointer and byte pulses
	always_ff @(posedge clock) begin
		if (rst_i) begin
			rd_mode_q <= 1'b0;
			addr_q    <= 8'h00;
			done_q    <= 1'b0;
			load_q    <= 1'b0;
		end else begin
			done_q <= byte_end && (state_q == ST_DATA);
			// Fetch after the address byte, then after each data byte
			// once the pointer has moved on
			load_q <= rd_mode_q && ((byte_end && (state_q == ST_ADDR)) || done_q);
			if (byte_end && (state_q == ST_CMD)) begin
				rd_mode_q <= (byte_in == HK_CMD_READ);
			end
			if (byte_end && (state_q == ST_ADDR)) begin
				addr_q <= byte_in;
			end else if (done_q) begin
				// Auto-increment after every data byte
				addr_q <= addr_q + 8'd1;
			end
		end
	end

	// Sample SDI on rising SCK
	always_ff @(posedge clock) begin
		if (spi_ev_i.sck_rise && !spi_ev_i.csb) begin
			shift_in_q <= byte_in[6:0];
		end
		if (byte_end) begin
			wdata_q <= byte_in;
		end
	end

	// Read shifter
	// Loads from the register file, shifts MSB first on falling SCK
	always_ff @(posedge clock) begin
		if (load_q) begin
			shift_out_q <= rdata_i;
		end else if (spi_ev_i.sck_fall) begin
			shift_out_q <= {shift_out_q[6:0], 1'b0};
		end
	end

	// SDO changes on falling SCK so the host samples on the next rise
	always_ff @(posedge clock) begin
		if (rst_i) begin
			sdo_o <= 1'b0;
		end else if (spi_ev_i.sck_fall) begin
			sdo_o <= shift_out_q[7];
		end
	end

	// Drive SDO only through the data bytes of a read
	assign sdo_enb_o = !((state_q == ST_DATA) && rd_mode_q);

	// Register file access
	assign bus_o.wr    = done_q && !rd_mode_q;
	assign bus_o.rd    = load_q;
	assign bus_o.addr  = addr_q;
	assign bus_o.wdata = wdata_q;

endmodule

// ==== housekeeping/hk_regs.sv ====
`timescale 1ns/1ps

module hk_regs (
	input  logic               clock,
	input  logic               rst_i,
	input  mgmt_pkg::hk_bus_t  bus_i,
	output logic [7:0]         rdata_o,
	input  logic [31:0]        mask_rev_i,
	input  logic               trap_i,
	output mgmt_pkg::pll_cfg_t pll_cfg_o,
	output logic               ext_reset_o,
	output logic               irq_o
);
	import mgmt_pkg::*;

	// Write decode
	always_ff @(posedge clock) begin
		if (rst_i) begin
			pll_cfg_o   <= PLL_CFG_RESET;
			ext_reset_o <= 1'b0;
			irq_o       <= 1'b0;
		end else begin
			// IRQ is a single-cycle pulse per write
			irq_o <= bus_i.wr && (bus_i.addr == REG_IRQ) && bus_i.wdata[0];
			if (bus_i.wr) begin
				case (bus_i.addr)
					REG_PLL_ENA: begin
						pll_cfg_o.ena     <= bus_i.wdata[0];
						pll_cfg_o.dco_ena <= bus_i.wdata[1];
					end
					REG_PLL_BYPASS: begin
						pll_cfg_o.bypass <= bus_i.wdata[0];
					end
					REG_EXT_RESET: begin
						ext_reset_o <= bus_i.wdata[0];
					end
					REG_PLL_SEL: begin
						pll_cfg_o.sel   <= bus_i.wdata[2:0];
						pll_cfg_o.sel90 <= bus_i.wdata[5:3];
					end
					REG_PLL_DIV: begin
						pll_cfg_o.div <= bus_i.wdata[4:0];
					end
					REG_PLL_TRIM0: begin
						pll_cfg_o.trim[7:0] <= bus_i.wdata;
					end
					REG_PLL_TRIM1: begin
						pll_cfg_o.trim[15:8] <= bus_i.wdata;
					end
					REG_PLL_TRIM2: begin
						pll_cfg_o.trim[23:16] <= bus_i.wdata;
					end
					REG_PLL_TRIM3: begin
						// Only two trim bits live in the top byte
						pll_cfg_o.trim[25:24] <= bus_i.wdata[1:0];
					end
					default: begin
						// Read-only and unmapped addresses drop the write
					end
				endcase
			end
		end
	end

	// Read mux
	// Combinational on address so the slave can fetch a cycle later
	always_comb begin
		case (bus_i.addr)
			REG_MASK_REV0:  rdata_o = mask_rev_i[7:0];
			REG_MASK_REV1:  rdata_o = mask_rev_i[15:8];
			REG_MASK_REV2:  rdata_o = mask_rev_i[23:16];
			REG_MASK_REV3:  rdata_o = mask_rev_i[31:24];
			REG_PLL_ENA:    rdata_o = {6'd0, pll_cfg_o.dco_ena, pll_cfg_o.ena};
			REG_PLL_BYPASS: rdata_o = {7'd0, pll_cfg_o.bypass};
			REG_IRQ:        rdata_o = {7'd0, irq_o};
			REG_EXT_RESET:  rdata_o = {7'd0, ext_reset_o};
			REG_TRAP:       rdata_o = {7'd0, trap_i};
			REG_PLL_SEL:    rdata_o = {2'd0, pll_cfg_o.sel90, pll_cfg_o.sel};
			REG_PLL_DIV:    rdata_o = {3'd0, pll_cfg_o.div};
			REG_PLL_TRIM0:  rdata_o = pll_cfg_o.trim[7:0];
			REG_PLL_TRIM1:  rdata_o = pll_cfg_o.trim[15:8];
			REG_PLL_TRIM2:  rdata_o = pll_cfg_o.trim[23:16];
			REG_PLL_TRIM3:  rdata_o = {6'd0, pll_cfg_o.trim[25:24]};
			default:        rdata_o = 8'h00;
		endcase
	end

endmodule

// ==== design/clock_ctrl.sv ====
`timescale 1ns/1ps

module clock_ctrl #(
	parameter int RESET_HOLD = 4
) (
	input  logic               clock,
	input  logic               rst_i,
	input  logic               ext_reset_i,
	input  mgmt_pkg::pll_cfg_t pll_cfg_i,
	output logic               core_rstn_o,
	output logic               user_tick_o
);
	localparam int HOLD_W = $clog2(RESET_HOLD + 1);

	logic [HOLD_W-1:0] hold_cnt_q;
	logic [4:0]        div_cnt_q;
	logic [4:0]        div_last_q;
	logic              free_run;
	logic              div_wrap;

	// Reset stretch
	// Either source pulls the core reset in the next cycle
	always_ff @(posedge clock) begin
		if (rst_i || ext_reset_i) begin
			hold_cnt_q  <= '0;
			core_rstn_o <= 1'b0;
		end else if (!core_rstn_o) begin
			// Release after RESET_HOLD quiet cycles
			if (hold_cnt_q == HOLD_W'(RESET_HOLD - 1)) begin
				core_rstn_o <= 1'b1;
			end else begin
				hold_cnt_q <= hold_cnt_q + 1'b1;
			end
		end
	end

	// Undivided when bypassed, disabled or divide of 0 or 1
	assign free_run = pll_cfg_i.bypass || !pll_cfg_i.ena || (pll_cfg_i.div <= 5'd1);

	// End of a divide period
	assign div_wrap = (div_cnt_q >= (pll_cfg_i.div - 5'd1));

	// Divider counter
	// Restarts on any change of the programmed divide
	always_ff @(posedge clock) begin
		if (rst_i) begin
			div_cnt_q  <= 5'd0;
			div_last_q <= 5'd0;
		end else begin
			div_last_q <= pll_cfg_i.div;
			if ((pll_cfg_i.div != div_last_q) || div_wrap) begin
				div_cnt_q <= 5'd0;
			end else begin
				div_cnt_q <= div_cnt_q + 5'd1;
			end
		end
	end

	// One enable per period stands in for the divided user clock
	assign user_tick_o = free_run || (div_cnt_q == 5'd0);

endmodule

// ==== design/pad_out_ctrl.sv ====
`timescale 1ns/1ps

module pad_out_ctrl #(
	parameter int MPRJ_IO_PADS = 38
) (
	input  logic                    clock,
	input  logic                    rst_i,
	input  logic [MPRJ_IO_PADS-1:0] mgmt_out_data_i,
	input  logic                    sdo_oenb_state_i,
	input  logic                    jtag_oenb_state_i,
	input  logic                    sdo_pre_i,
	input  logic                    sdo_enb_i,
	output logic                    sdo_o,
	output logic                    sdo_oeb_o,
	output logic                    jtag_o,
	output logic                    jtag_oeb_o
);
	logic sdo_next;
	logic jtag_next;

	// SoC takes over SDO when its pad is configured as an output
	assign sdo_next = (sdo_oenb_state_i == 1'b0) ? mgmt_out_data_i[1] : sdo_pre_i;

	// No JTAG engine here
	// Pad idles low unless the SoC overrides it
	assign jtag_next = (jtag_oenb_state_i == 1'b0) ? mgmt_out_data_i[0] : 1'b0;

	// Pad drivers
	always_ff @(posedge clock) begin
		if (rst_i) begin
			sdo_o      <= 1'b0;
			sdo_oeb_o  <= 1'b1;
			jtag_o     <= 1'b0;
			jtag_oeb_o <= 1'b1;
		end else begin
			sdo_o      <= sdo_next;
			// Enable follows the SPI slave only
			sdo_oeb_o  <= sdo_enb_i;
			jtag_o     <= jtag_next;
			// JTAG pad is never driven from this side
			jtag_oeb_o <= 1'b1;
		end
	end

endmodule

// ==== design/mgmt_core.sv ====
`timescale 1ns/1ps

module mgmt_core #(
	parameter int MPRJ_IO_PADS = 38,
	parameter int RESET_HOLD   = 4
) (
	input  logic                    clock,
	input  logic                    rst_i,
	input  logic [MPRJ_IO_PADS-1:0] mgmt_in_data_i,
	input  logic [MPRJ_IO_PADS-1:0] mgmt_out_data_i,
	input  logic                    hk_connect_i,
	input  logic                    sdo_oenb_state_i,
	input  logic                    jtag_oenb_state_i,
	input  logic                    trap_i,
	input  logic [31:0]             mask_rev_i,
	output logic                    sdo_o,
	output logic                    sdo_oeb_o,
	output logic                    jtag_o,
	output logic                    jtag_oeb_o,
	output mgmt_pkg::pll_cfg_t      pll_cfg_o,
	output logic                    irq_o,
	output logic                    core_rstn_o,
	output logic                    user_tick_o
);
	import mgmt_pkg::*;

	spi_ev_t    spi_ev;
	hk_bus_t    hk_bus;
	logic [7:0] hk_rdata;
	logic       sdo_pre;
	logic       sdo_enb;
	logic       ext_reset;

	// SPI pin select and synchronizer
	hk_pin_sync #(
		.MPRJ_IO_PADS(MPRJ_IO_PADS)
	) u_pin_sync (
		.clock           (clock),
		.rst_i           (rst_i),
		.mgmt_in_data_i  (mgmt_in_data_i),
		.mgmt_out_data_i (mgmt_out_data_i),
		.hk_connect_i    (hk_connect_i),
		.spi_ev_o        (spi_ev)
	);

	// Housekeeping SPI slave
	hk_spi_slave u_spi_slave (
		.clock     (clock),
		.rst_i     (rst_i),
		.spi_ev_i  (spi_ev),
		.bus_o     (hk_bus),
		.rdata_i   (hk_rdata),
		.sdo_o     (sdo_pre),
		.sdo_enb_o (sdo_enb)
	);

	// Register file
	hk_regs u_regs (
		.clock       (clock),
		.rst_i       (rst_i),
		.bus_i       (hk_bus),
		.rdata_o     (hk_rdata),
		.mask_rev_i  (mask_rev_i),
		.trap_i      (trap_i),
		.pll_cfg_o   (pll_cfg_o),
		.ext_reset_o (ext_reset),
		.irq_o       (irq_o)
	);

	// Core reset and user clock enable
	clock_ctrl #(
		.RESET_HOLD(RESET_HOLD)
	) u_clock_ctrl (
		.clock       (clock),
		.rst_i       (rst_i),
		.ext_reset_i (ext_reset),
		.pll_cfg_i   (pll_cfg_o),
		.core_rstn_o (core_rstn_o),
		.user_tick_o (user_tick_o)
	);

	// SDO and JTAG pads
	pad_out_ctrl #(
		.MPRJ_IO_PADS(MPRJ_IO_PADS)
	) u_pad_out (
		.clock             (clock),
		.rst_i             (rst_i),
		.mgmt_out_data_i   (mgmt_out_data_i),
		.sdo_oenb_state_i  (sdo_oenb_state_i),
		.jtag_oenb_state_i (jtag_oenb_state_i),
		.sdo_pre_i         (sdo_pre),
		.sdo_enb_i         (sdo_enb),
		.sdo_o             (sdo_o),
		.sdo_oeb_o         (sdo_oeb_o),
		.jtag_o            (jtag_o),
		.jtag_oeb_o        (jtag_oeb_o)
	);

endmodule

// ==== tb/mgmt_core_checker.sv ====
`timescale 1ns/1ps

module mgmt_core_checker (
	input logic clock,
	input logic rst_i,
	input logic csb_i,
	input logic sdo_oeb_i,
	input logic core_rstn_i,
	input logic irq_i
);
	// Count of failed assertions
	int unsigned fail_cnt = 0;

	// SDO released once CSB has been idle through the slave and pad stages
	a_sdo_idle: assert property (@(posedge clock) disable iff (rst_i)
		csb_i && $past(csb_i) && $past(csb_i, 2) |-> sdo_oeb_i)
	else begin
		$error("sdo_oeb_o driven low while CSB is idle");
		fail_cnt++;
	end

	// Chip reset always reaches the core reset
	a_rst_core: assert property (@(posedge clock) rst_i |=> !core_rstn_i)
	else begin
		$error("core_rstn_o high in the cycle after rst_i");
		fail_cnt++;
	end

	// IRQ is a single cycle pulse
	a_irq_pulse: assert property (@(posedge clock) disable iff (rst_i)
		irq_i |=> !irq_i)
	else begin
		$error("irq_o high for two cycles in a row");
		fail_cnt++;
	end

endmodule

bind mgmt_core mgmt_core_checker u_checker (
	.clock       (clock),
	.rst_i       (rst_i),
	.csb_i       (spi_ev.csb),
	.sdo_oeb_i   (sdo_oeb_o),
	.core_rstn_i (core_rstn_o),
	.irq_i       (irq_o)
);

// ==== tb/mgmt_core_tb.sv ====
`timescale 1ns/1ps

module mgmt_core_tb;
	import mgmt_pkg::*;

	localparam int PADS            = 38;
	localparam int HALF            = 10;
	localparam int CYCLES_PER_LINE = 2000;

	logic            clock;
	logic            rst_i;
	logic [PADS-1:0] mgmt_in_data_i;
	logic [PADS-1:0] mgmt_out_data_i;
	logic            hk_connect_i;
	logic            sdo_oenb_state_i;
	logic            jtag_oenb_state_i;
	logic            trap_i;
	logic [31:0]     mask_rev_i;
	logic            sdo_o;
	logic            sdo_oeb_o;
	logic            jtag_o;
	logic            jtag_oeb_o;
	pll_cfg_t        pll_cfg_o;
	logic            irq_o;
	logic            core_rstn_o;
	logic            user_tick_o;

	string lines[$];
	string test_name = "";
	int    watchdog_cycles = 0;
	int    errors = 0;
	int    checks = 0;
	int    test_base = 0;
	int    tests_run = 0;
	int    tests_failed = 0;
	int    irq_seen = 0;

	mgmt_core #(
		.MPRJ_IO_PADS(PADS),
		.RESET_HOLD  (4)
	) uut (
		.clock             (clock),
		.rst_i             (rst_i),
		.mgmt_in_data_i    (mgmt_in_data_i),
		.mgmt_out_data_i   (mgmt_out_data_i),
		.hk_connect_i      (hk_connect_i),
		.sdo_oenb_state_i  (sdo_oenb_state_i),
		.jtag_oenb_state_i (jtag_oenb_state_i),
		.trap_i            (trap_i),
		.mask_rev_i        (mask_rev_i),
		.sdo_o             (sdo_o),
		.sdo_oeb_o         (sdo_oeb_o),
		.jtag_o            (jtag_o),
		.jtag_oeb_o        (jtag_oeb_o),
		.pll_cfg_o         (pll_cfg_o),
		.irq_o             (irq_o),
		.core_rstn_o       (core_rstn_o),
		.user_tick_o       (user_tick_o)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// IRQ cycles counted away from the active edge
	always @(negedge clock) begin
		if (irq_o) begin
			irq_seen++;
		end
	end

	// Budget scales with trace length
	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clock);
		$display("Timeout: trace did not complete within %0d cycles", watchdog_cycles);
		$display("Some tests failed");
		$finish;
	end

	// Always returns 1 ns after a rising edge
	task automatic step_cycles(input int n);
		repeat (n) @(posedge clock);
		#1;
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_pll(input string name, input pll_cfg_t got, input pll_cfg_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// SCK bit 4, CSB bit 3, SDI bit 2 on the selected side
	// Unselected side parks idle
	task automatic set_spi_pins(input logic sck, input logic csb, input logic sdi);
		if (hk_connect_i) begin
			mgmt_out_data_i[4:2] = {sck, csb, sdi};
			mgmt_in_data_i[4:2]  = 3'b010;
		end else begin
			mgmt_in_data_i[4:2]  = {sck, csb, sdi};
			mgmt_out_data_i[4:2] = 3'b010;
		end
	endtask

	// Mode 0 frame sent MSB first
	// Bytes after the first two are data
	// Their SDO bits come back in rx_q
	task automatic spi_frame(input logic [7:0] tx_q[$], input logic rd_frame,
		output logic [7:0] rx_q[$]);
		logic [7:0] tx;
		logic [7:0] rx;
		int         i;
		rx_q = {};
		set_spi_pins(1'b0, 1'b0, 1'b0);
		step_cycles(HALF);
		for (i = 0; i < tx_q.size(); i++) begin
			tx = tx_q[i];
			rx = 8'h00;
			repeat (8) begin
				set_spi_pins(1'b0, 1'b0, tx[7]);
				step_cycles(HALF);
				// Host samples just before its rising edge
				rx = {rx[6:0], sdo_o};
				// SDO pad enabled only through the data bytes of a read
				check_bit("sdo_oeb_o", sdo_oeb_o, !(rd_frame && i >= 2));
				set_spi_pins(1'b1, 1'b0, tx[7]);
				step_cycles(HALF);
				tx = {tx[6:0], 1'b0};
			end
			if (i >= 2) begin
				rx_q.push_back(rx);
			end
		end
		set_spi_pins(1'b0, 1'b0, 1'b0);
		step_cycles(HALF);
		set_spi_pins(1'b0, 1'b1, 1'b0);
		step_cycles(HALF);
	endtask

	task automatic close_test();
		if (test_name != "") begin
			tests_run++;
			if (errors != test_base) begin
				tests_failed++;
			end
			$display("Test %s %s, %0d errors", test_name,
				(errors == test_base) ? "ok" : "FAILED", errors - test_base);
		end
		test_base = errors;
	endtask

	// One trace operation
	task automatic run_line(input string line);
		string      op;
		string      kind;
		logic [7:0] addr;
		logic [7:0] d0, d1, d2, d3;
		logic [7:0] data[$];
		logic [7:0] tx_q[$];
		logic [7:0] rx_q[$];
		logic       hk, sdo_st, jtag_st, trap_v;
		logic [1:0] out_bits;
		logic [31:0] mask;
		logic [39:0] val;
		int         n;
		int         k;
		int         gap;
		op = "";
		void'($sscanf(line, "%s", op));
		if (op == "T") begin
			close_test();
			void'($sscanf(line, "%s %s", op, test_name));
		end else if (op == "W" || op == "R") begin
			void'($sscanf(line, "%s %h %d %h %h %h %h", op, addr, n, d0, d1, d2, d3));
			data = '{d0, d1, d2, d3};
			while (data.size() > n) begin
				data.pop_back();
			end
			tx_q = {};
			tx_q.push_back((op == "W") ? HK_CMD_WRITE : HK_CMD_READ);
			tx_q.push_back(addr);
			// Read frames clock out zeros as filler
			foreach (data[j]) begin
				tx_q.push_back((op == "W") ? data[j] : 8'h00);
			end
			spi_frame(tx_q, op == "R", rx_q);
			if (op == "R") begin
				for (k = 0; k < n; k++) begin
					check_byte($sformatf("rdata[%h]", 8'(addr + k)), rx_q[k], data[k]);
				end
			end
		end else if (op == "P") begin
			void'($sscanf(line, "%s %h %h %h %h %h %h", op, hk, sdo_st, jtag_st, out_bits,
				trap_v, mask));
			hk_connect_i         = hk;
			sdo_oenb_state_i     = sdo_st;
			jtag_oenb_state_i    = jtag_st;
			mgmt_out_data_i[1:0] = out_bits;
			trap_i               = trap_v;
			mask_rev_i           = mask;
			set_spi_pins(1'b0, 1'b1, 1'b0);
			step_cycles(4);
		end else if (op == "C") begin
			void'($sscanf(line, "%s %s %h", op, kind, val));
			if (kind == "pll") begin
				check_pll("pll_cfg_o", pll_cfg_o, pll_cfg_t'(val));
			end else if (kind == "irq") begin
				check_byte("irq_o pulses", 8'(irq_seen), val[7:0]);
				irq_seen = 0;
			end else if (kind == "rstn") begin
				// Allow the reset stretch to run out
				for (k = 0; k < 20 && core_rstn_o !== val[0]; k++) begin
					step_cycles(1);
				end
				check_bit("core_rstn_o", core_rstn_o, val[0]);
			end else if (kind == "tick") begin
				while (!user_tick_o) begin
					step_cycles(1);
				end
				// Three full periods between strobes
				repeat (3) begin
					gap = 0;
					do begin
						step_cycles(1);
						gap++;
					end while (!user_tick_o);
					check_byte("user_tick_o period", 8'(gap), val[7:0]);
				end
			end else if (kind == "pad") begin
				check_bit("sdo_o", sdo_o, val[1]);
				check_bit("jtag_o", jtag_o, val[0]);
			end else begin
				errors++;
				$display("Trace has an unknown check kind: %s", kind);
			end
		end else if (op != "" && op != "#") begin
			errors++;
			$display("Trace has an unknown operation: %s", op);
		end
	endtask

	initial begin
		int    fd;
		int    rc;
		string line;
		rst_i             = 1'b1;
		mgmt_in_data_i    = '0;
		mgmt_out_data_i   = '0;
		mgmt_in_data_i[3] = 1'b1;
		mgmt_out_data_i[3] = 1'b1;
		hk_connect_i      = 1'b0;
		sdo_oenb_state_i  = 1'b1;
		jtag_oenb_state_i = 1'b1;
		trap_i            = 1'b0;
		mask_rev_i        = 32'h0;
		fd = $fopen("tb/mgmt_core_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file tb/mgmt_core_trace.txt");
			$display("Some tests failed");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				rc = $fgets(line, fd);
				if (rc > 0) begin
					lines.push_back(line);
				end
			end
			$fclose(fd);
			watchdog_cycles = lines.size() * CYCLES_PER_LINE;
			step_cycles(16);
			rst_i = 1'b0;
			step_cycles(1);
			// State straight out of reset
			test_name = "reset_state";
			check_pll("pll_cfg_o", pll_cfg_o, PLL_CFG_RESET);
			check_bit("core_rstn_o", core_rstn_o, 1'b0);
			check_bit("irq_o", irq_o, 1'b0);
			check_bit("sdo_oeb_o", sdo_oeb_o, 1'b1);
			check_bit("jtag_oeb_o", jtag_oeb_o, 1'b1);
			close_test();
			test_name = "";
			foreach (lines[idx]) begin
				run_line(lines[idx]);
			end
			close_test();
			errors += uut.u_checker.fail_cnt;
			$display("Tests run %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
				tests_run, tests_failed, checks, errors, uut.u_checker.fail_cnt);
			if (errors == 0 && tests_failed == 0) begin
				$display("All tests passed");
			end else begin
				$display("Some tests failed");
			end
			$finish;
		end
	end

endmodule

// ==== tb/mgmt_core_trace.txt ====
# T name | W addr count d0 d1 d2 d3 | R addr count e0 e1 e2 e3 (four byte fields always)
# P hk_connect sdo_state jtag_state out_bits trap mask_rev | C pll|irq|rstn|tick|pad value
T reset_regs
R 08 4 00 01 00 00
R 0c 4 00 00 04 00
R 10 4 00 00 00 00
T pll_write
W 10 4 5a c3 96 02
W 0d 2 1d 07 00 00
R 10 4 5a c3 96 02
R 0d 2 1d 07 00 00
C pll 359e96c35a
T mask_trap
P 0 1 1 0 1 a5c31e07
R 01 4 07 1e c3 a5
R 0c 1 01 00 00 00
T ext_reset_tick
W 0b 1 01 00 00 00
C rstn 0
W 0b 1 00 00 00 00
C rstn 1
W 08 2 01 00 00 00
W 0e 1 03 00 00 00
C pll 958e96c35a
C tick 3
T irq_unmapped
C irq 0
W 0a 1 01 00 00 00
C irq 1
R 0f 1 00 00 00 00
R 20 2 00 00 00 00
T soc_pins
P 1 1 1 0 1 a5c31e07
W 0e 1 05 00 00 00
R 0e 1 05 00 00 00
P 0 0 0 2 1 a5c31e07
C pad 2
P 0 0 0 1 1 a5c31e07
C pad 1

// ==== mgmt_core.f ====
common/mgmt_pkg.sv
housekeeping/hk_pin_sync.sv
housekeeping/hk_spi_slave.sv
housekeeping/hk_regs.sv
design/clock_ctrl.sv
design/pad_out_ctrl.sv
design/mgmt_core.sv
tb/mgmt_core_checker.sv
tb/mgmt_core_tb.sv

// ==== Makefile ====
TOP := mgmt_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f mgmt_core.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf obj_dir
